// File: common/flow_control_pkg.sv
// Shared widths, address map and types for the flow-control block; import wherever these are used
package flow_control_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    localparam int PC_WIDTH     = 10;
    localparam int WORD_WIDTH   = 36;
    localparam int ADDR_WIDTH   = 10;
    localparam int THREAD_WIDTH = 2;

    typedef logic [PC_WIDTH-1:0]     pc_t;
    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [THREAD_WIDTH-1:0] thread_t;

    // ----------------------------------------
    // Threads and pipeline
    // ----------------------------------------

    localparam int THREAD_COUNT = 4;

    // Cycles from PC issue to resolution, kept below THREAD_COUNT
    localparam int FETCH_DEPTH = 2;

    // Thread t starts at t * THREAD_START_STRIDE
    localparam int THREAD_START_STRIDE = 64;

    // ----------------------------------------
    // Branch configuration map
    // ----------------------------------------

    localparam int BRANCH_COUNT = 4;

    localparam addr_t CONFIG_ADDR_BASE = 10'h200;

    // Words per branch and their offsets
    localparam int BRANCH_CONFIG_ENTRIES = 3;
    localparam int OFFSET_ORIGIN         = 0;
    localparam int OFFSET_DESTINATION    = 1;
    localparam int OFFSET_CONTROL        = 2;

    // Control word: condition in the low bits, then cancel enable
    localparam int COND_WIDTH      = 3;
    localparam int CTRL_CANCEL_BIT = 3;

    typedef enum logic [COND_WIDTH-1:0] {
        COND_NEVER      = 3'd0,
        COND_ALWAYS     = 3'd1,
        COND_A_NEGATIVE = 3'd2,
        COND_A_CARRYOUT = 3'd3,
        COND_A_EXTERNAL = 3'd4,
        COND_B_LESSTHAN = 3'd5,
        COND_B_EXTERNAL = 3'd6,
        COND_R_ZERO     = 3'd7
    } branch_cond_e;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------

    // ALU flags aligned with the resolving instruction
    typedef struct packed {
        logic a_negative;
        logic a_carryout;
        logic a_external;
        logic b_lessthan;
        logic b_external;
    } flags_t;

    // One branch proposal, also the arbitrated result
    typedef struct packed {
        logic jump;
        logic cancel;
        pc_t  destination;
    } branch_req_t;

endpackage

// File: flow_control/branch_unit.sv
// One programmable branch: holds its memory-mapped configuration and proposes a jump
`timescale 1ns/1ps

module branch_unit
    import flow_control_pkg::*;
#(
    parameter int BRANCH_INDEX = 0
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        write_previous,
    input  logic        cancel_previous,
    input  addr_t       config_addr,
    input  word_t       config_data,
    input  pc_t         pc_current,
    input  flags_t      flags,
    input  word_t       r_previous,
    output branch_req_t req
);

    // Unit index must select an existing slot in the address map
    if (BRANCH_INDEX < 0 || BRANCH_INDEX >= BRANCH_COUNT) begin : g_index_check
        $error("branch_unit: BRANCH_INDEX out of range");
    end

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    localparam addr_t UNIT_BASE =
        addr_t'(CONFIG_ADDR_BASE + BRANCH_INDEX * BRANCH_CONFIG_ENTRIES);
    localparam addr_t ORIGIN_ADDR      = addr_t'(UNIT_BASE + OFFSET_ORIGIN);
    localparam addr_t DESTINATION_ADDR = addr_t'(UNIT_BASE + OFFSET_DESTINATION);
    localparam addr_t CONTROL_ADDR     = addr_t'(UNIT_BASE + OFFSET_CONTROL);

    logic         write_ok;
    pc_t          origin;
    pc_t          destination;
    branch_cond_e condition;
    logic         cancel_enable;
    logic         origin_match;
    logic         cond_true;

    // Previous instruction wrote and was not annulled
    assign write_ok = write_previous & ~cancel_previous;

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            origin        <= '0;
            destination   <= '0;
            condition     <= COND_NEVER;
            cancel_enable <= 1'b0;
        end else if (write_ok) begin
            case (config_addr)
                ORIGIN_ADDR: begin
                    origin <= config_data[PC_WIDTH-1:0];
                end
                DESTINATION_ADDR: begin
                    destination <= config_data[PC_WIDTH-1:0];
                end
                CONTROL_ADDR: begin
                    condition     <= branch_cond_e'(config_data[COND_WIDTH-1:0]);
                    cancel_enable <= config_data[CTRL_CANCEL_BIT];
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------
    // Origin match and condition test
    // ----------------------------------------

    assign origin_match = (pc_current == origin);

    always_comb begin
        case (condition)
            COND_NEVER:      cond_true = 1'b0;
            COND_ALWAYS:     cond_true = 1'b1;
            COND_A_NEGATIVE: cond_true = flags.a_negative;
            COND_A_CARRYOUT: cond_true = flags.a_carryout;
            COND_A_EXTERNAL: cond_true = flags.a_external;
            COND_B_LESSTHAN: cond_true = flags.b_lessthan;
            COND_B_EXTERNAL: cond_true = flags.b_external;
            COND_R_ZERO:     cond_true = (r_previous == '0);
            default:         cond_true = 1'b0;
        endcase
    end

    assign req.jump        = origin_match & cond_true;
    assign req.cancel      = req.jump & cancel_enable;
    assign req.destination = destination;

    // Annulling the successor only makes sense for a taken branch
    a_cancel_needs_jump: assert property (
        @(posedge clock) disable iff (!rst_n) req.cancel |-> req.jump
    );

endmodule

// File: flow_control/branch_arbiter.sv
// Priority combiner for the parallel branch proposals; lowest index wins
`timescale 1ns/1ps

module branch_arbiter
    import flow_control_pkg::*;
(
    input  branch_req_t [BRANCH_COUNT-1:0] reqs,
    output branch_req_t                    winner
);

    logic any_jump;

    // ----------------------------------------
    // Priority scan
    // ----------------------------------------

    // Walk from the top so the lowest firing index is written last
    always_comb begin
        winner = '0;
        for (int i = BRANCH_COUNT - 1; i >= 0; i--) begin
            if (reqs[i].jump) begin
                winner = reqs[i];
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // OR of all input jump bits, independent of the scan
    always_comb begin
        any_jump = 1'b0;
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            any_jump = any_jump | reqs[i].jump;
        end
    end

    // A taken jump must come from some firing unit
    always_comb begin
        a_winner_has_source: assert (!winner.jump || any_jump);
    end

endmodule

// File: flow_control/pc_controller.sv
// Per-thread PC state: issues PCs round-robin and writes each thread's next PC at resolution
`timescale 1ns/1ps

module pc_controller
    import flow_control_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        io_ready,
    input  branch_req_t winner,
    output pc_t         pc,
    output pc_t         pc_current
);

    thread_t                thread_issue;
    pc_t                    pc_regs     [THREAD_COUNT];
    pc_t                    pipe_pc     [FETCH_DEPTH];
    thread_t                pipe_thread [FETCH_DEPTH];
    logic [FETCH_DEPTH-1:0] pipe_valid;
    thread_t                thread_current;
    logic                   resolve_valid;
    pc_t                    pc_next;

    // ----------------------------------------
    // Issue
    // ----------------------------------------

    // Wraps naturally since THREAD_COUNT fills the counter
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_issue <= '0;
        end else begin
            thread_issue <= thread_issue + thread_t'(1);
        end
    end

    assign pc = pc_regs[thread_issue];

    // ----------------------------------------
    // Fetch delay line
    // ----------------------------------------

    always_ff @(posedge clock) begin
        pipe_pc[0]     <= pc;
        pipe_thread[0] <= thread_issue;
        for (int s = 1; s < FETCH_DEPTH; s++) begin
            pipe_pc[s]     <= pipe_pc[s-1];
            pipe_thread[s] <= pipe_thread[s-1];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= 1'b1;
            for (int s = 1; s < FETCH_DEPTH; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    assign pc_current     = pipe_pc[FETCH_DEPTH-1];
    assign thread_current = pipe_thread[FETCH_DEPTH-1];
    assign resolve_valid  = pipe_valid[FETCH_DEPTH-1];

    // ----------------------------------------
    // Next PC
    // ----------------------------------------

    // A stall beats a jump: the instruction must repeat first
    always_comb begin
        if (!io_ready) begin
            pc_next = pc_current;
        end else if (winner.jump) begin
            pc_next = winner.destination;
        end else begin
            pc_next = pc_current + pc_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc_regs[t] <= pc_t'(t * THREAD_START_STRIDE);
            end
        end else if (resolve_valid) begin
            pc_regs[thread_current] <= pc_next;
        end
    end

    // Write port and issue read never target the same thread
    a_resolve_not_issue: assert property (
        @(posedge clock) disable iff (!rst_n)
        resolve_valid |-> (thread_current != thread_issue)
    );

endmodule

// File: flow_control/flow_control.sv
// Flow-control top: parallel branch units, priority arbiter and per-thread PC controller
`timescale 1ns/1ps

module flow_control
    import flow_control_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   io_ready,
    input  logic   write_previous,
    input  logic   cancel_previous,
    input  flags_t flags,
    input  word_t  r_previous,
    input  addr_t  config_addr,
    input  word_t  config_data,
    output pc_t    pc,
    output logic   cancel
);

    pc_t                           pc_current;
    branch_req_t [BRANCH_COUNT-1:0] reqs;
    branch_req_t                   winner;

    // ----------------------------------------
    // Branch units, one config slot each
    // ----------------------------------------

    for (genvar b = 0; b < BRANCH_COUNT; b++) begin : g_branch
        branch_unit #(
            .BRANCH_INDEX    (b)
        ) i_branch_unit (
            .clock           (clock),
            .rst_n           (rst_n),
            .write_previous  (write_previous),
            .cancel_previous (cancel_previous),
            .config_addr     (config_addr),
            .config_data     (config_data),
            .pc_current      (pc_current),
            .flags           (flags),
            .r_previous      (r_previous),
            .req             (reqs[b])
        );
    end

    // ----------------------------------------
    // Arbitration
    // ----------------------------------------

    branch_arbiter i_branch_arbiter (
        .reqs   (reqs),
        .winner (winner)
    );

    assign cancel = winner.cancel;

    // ----------------------------------------
    // PC state and issue
    // ----------------------------------------

    pc_controller i_pc_controller (
        .clock      (clock),
        .rst_n      (rst_n),
        .io_ready   (io_ready),
        .winner     (winner),
        .pc         (pc),
        .pc_current (pc_current)
    );

endmodule

// File: sim/tb_flow_control.sv
// Random-stimulus testbench for flow_control; checks pc and cancel against a cycle model every cycle
`timescale 1ns/1ps

module tb_flow_control
    import flow_control_pkg::*;
();

    localparam int RUN_CYCLES      = 3000;
    localparam int QUIET_CYCLES    = 12;
    localparam int RESET_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + RESET_CYCLES + 100;
    localparam int CONFIG_WORDS    = BRANCH_COUNT * BRANCH_CONFIG_ENTRIES;

    logic   clock;
    logic   rst_n;
    logic   io_ready;
    logic   write_previous;
    logic   cancel_previous;
    flags_t flags;
    word_t  r_previous;
    addr_t  config_addr;
    word_t  config_data;
    pc_t    pc;
    logic   cancel;

    // Reference model state
    pc_t          m_origin    [BRANCH_COUNT];
    pc_t          m_dest      [BRANCH_COUNT];
    branch_cond_e m_cond      [BRANCH_COUNT];
    logic         m_cancel_en [BRANCH_COUNT];
    pc_t          m_pc        [THREAD_COUNT];
    pc_t          q_pc        [FETCH_DEPTH];
    thread_t      q_thread    [FETCH_DEPTH];
    logic         q_valid     [FETCH_DEPTH];
    thread_t      m_issue;

    logic [31:0] rng_state;
    int          check_count;
    int          error_count;
    int          jump_count;
    int          stall_count;
    int          write_count;

    flow_control i_dut (
        .clock           (clock),
        .rst_n           (rst_n),
        .io_ready        (io_ready),
        .write_previous  (write_previous),
        .cancel_previous (cancel_previous),
        .flags           (flags),
        .r_previous      (r_previous),
        .config_addr     (config_addr),
        .config_data     (config_data),
        .pc              (pc),
        .cancel          (cancel)
    );

    always #4 clock = ~clock;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic cond_holds(input branch_cond_e cond, input flags_t f, input word_t r);
        logic holds;
        case (cond)
            COND_ALWAYS:     holds = 1'b1;
            COND_A_NEGATIVE: holds = f.a_negative;
            COND_A_CARRYOUT: holds = f.a_carryout;
            COND_A_EXTERNAL: holds = f.a_external;
            COND_B_LESSTHAN: holds = f.b_lessthan;
            COND_B_EXTERNAL: holds = f.b_external;
            COND_R_ZERO:     holds = (r == '0);
            default:         holds = 1'b0;
        endcase
        return holds;
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    task automatic reset_model();
        for (int b = 0; b < BRANCH_COUNT; b++) begin
            m_origin[b]    = '0;
            m_dest[b]      = '0;
            m_cond[b]      = COND_NEVER;
            m_cancel_en[b] = 1'b0;
        end
        for (int t = 0; t < THREAD_COUNT; t++) begin
            m_pc[t] = pc_t'(t * THREAD_START_STRIDE);
        end
        for (int s = 0; s < FETCH_DEPTH; s++) begin
            q_pc[s]     = '0;
            q_thread[s] = '0;
            q_valid[s]  = 1'b0;
        end
        m_issue = '0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic drive_inputs(input logic random_on);
        logic [31:0] r;
        int          slot;
        word_t       data;
        r          = next_random();
        flags      = flags_t'(r[22:18]);
        r_previous = (r[17:16] == 2'b00) ? '0 : word_t'({next_random(), next_random()});
        if (random_on) begin
            io_ready        = (r[14:12] != 3'b000);
            write_previous  = r[0];
            cancel_previous = (r[4:2] == 3'b000);
            data            = word_t'({next_random(), next_random()});
            if (r[11:8] < 4'd11) begin
                slot        = int'(next_random() % CONFIG_WORDS);
                config_addr = addr_t'(int'(CONFIG_ADDR_BASE) + slot);
                // Origin a few steps ahead of a live PC so the branch gets hit
                if (slot % BRANCH_CONFIG_ENTRIES == OFFSET_ORIGIN) begin
                    data[PC_WIDTH-1:0] = m_pc[r[25:24]] + pc_t'(r[27:26]);
                end
            end else begin
                config_addr = addr_t'(next_random());
            end
            config_data = data;
        end else begin
            io_ready        = 1'b1;
            write_previous  = 1'b0;
            cancel_previous = 1'b0;
            config_addr     = '0;
            config_data     = '0;
        end
    endtask

    // ----------------------------------------
    // One cycle: drive, check, advance model
    // ----------------------------------------

    task automatic run_cycle(input int cycle);
        logic exp_jump;
        logic exp_cancel;
        pc_t  exp_dest;
        pc_t  issued_pc;
        int   slot;
        drive_inputs(cycle >= QUIET_CYCLES);
        #1;
        // Lowest-numbered firing branch wins
        exp_jump   = 1'b0;
        exp_cancel = 1'b0;
        exp_dest   = '0;
        for (int b = 0; b < BRANCH_COUNT; b++) begin
            if (!exp_jump && q_pc[FETCH_DEPTH-1] == m_origin[b]
                    && cond_holds(m_cond[b], flags, r_previous)) begin
                exp_jump   = 1'b1;
                exp_cancel = m_cancel_en[b];
                exp_dest   = m_dest[b];
            end
        end
        issued_pc = m_pc[m_issue];
        if (cycle < THREAD_COUNT) begin
            check_value("pc at start", word_t'(pc), word_t'(cycle * THREAD_START_STRIDE));
        end
        check_value("pc", word_t'(pc), word_t'(issued_pc));
        check_value("cancel", word_t'(cancel), word_t'(exp_cancel));

        // Resolution at the edge that ends this cycle
        if (q_valid[FETCH_DEPTH-1]) begin
            if (!io_ready) begin
                stall_count++;
            end else if (exp_jump) begin
                m_pc[q_thread[FETCH_DEPTH-1]] = exp_dest;
                jump_count++;
            end else begin
                m_pc[q_thread[FETCH_DEPTH-1]] = q_pc[FETCH_DEPTH-1] + pc_t'(1);
            end
        end

        slot = int'(config_addr) - int'(CONFIG_ADDR_BASE);
        if (write_previous && !cancel_previous && slot >= 0 && slot < CONFIG_WORDS) begin
            write_count++;
            case (slot % BRANCH_CONFIG_ENTRIES)
                OFFSET_ORIGIN: begin
                    m_origin[slot / BRANCH_CONFIG_ENTRIES] = config_data[PC_WIDTH-1:0];
                end
                OFFSET_DESTINATION: begin
                    m_dest[slot / BRANCH_CONFIG_ENTRIES] = config_data[PC_WIDTH-1:0];
                end
                default: begin
                    m_cond[slot / BRANCH_CONFIG_ENTRIES] =
                        branch_cond_e'(config_data[COND_WIDTH-1:0]);
                    m_cancel_en[slot / BRANCH_CONFIG_ENTRIES] = config_data[CTRL_CANCEL_BIT];
                end
            endcase
        end

        for (int s = FETCH_DEPTH - 1; s > 0; s--) begin
            q_pc[s]     = q_pc[s-1];
            q_thread[s] = q_thread[s-1];
            q_valid[s]  = q_valid[s-1];
        end
        q_pc[0]     = issued_pc;
        q_thread[0] = m_issue;
        q_valid[0]  = 1'b1;
        m_issue     = m_issue + thread_t'(1);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin : main
        clock           = 1'b0;
        rst_n           = 1'b0;
        io_ready        = 1'b1;
        write_previous  = 1'b0;
        cancel_previous = 1'b0;
        flags           = '0;
        r_previous      = '0;
        config_addr     = '0;
        config_data     = '0;
        rng_state       = 32'd46;
        check_count     = 0;
        error_count     = 0;
        jump_count      = 0;
        stall_count     = 0;
        write_count     = 0;
        reset_model();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clock);
        end
        rst_n = 1'b1;
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            if (cycle > 0) begin
                @(negedge clock);
            end
            run_cycle(cycle);
        end
        $display("Checks: %0d, errors: %0d, taken branches: %0d, stalls: %0d, config writes: %0d",
            check_count, error_count, jump_count, stall_count, write_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        for (int w = 0; w < WATCHDOG_CYCLES; w++) begin
            #8;
        end
        $display("Timeout: the run did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: sources.f
common/flow_control_pkg.sv
flow_control/branch_unit.sv
flow_control/branch_arbiter.sv
flow_control/pc_controller.sv
flow_control/flow_control.sv
sim/tb_flow_control.sv

// File: Makefile
# Verilator build, run and lint for the flow-control block

VERILATOR ?= verilator
TOP       ?= tb_flow_control
DUT_TOP   ?= flow_control
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -j 0
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
